//--- pea.f
+incdir+src
src/pea_pkg.sv
src/pea_config_regs.sv
src/pea_enable.sv
src/pea_firing_fsm.sv
src/pea_top.sv
verification/pea_token_fifo.sv
verification/pea_tb.sv

//--- run_pea.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -f pea.f --top-module pea_tb -o pea_sim

./obj_dir/pea_sim > sim.log
cat sim.log

if grep -q "All tests passed" sim.log; then
   exit 0
else
   exit 1
fi

//--- src/pea_config_regs.sv
`include "pea_defs.svh"

module pea_config_regs
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            load_coeff,
   input  logic                            load_bias,
   input  logic signed [7:0]               load_value,
   output logic signed [`PEA_RESULT_W-1:0] coeff,
   output logic signed [`PEA_RESULT_W-1:0] bias
);

   logic signed [`PEA_RESULT_W-1:0] value_ext;

   // immediates are stored at full result width so the MAC needs no extension
   assign value_ext = {{(`PEA_RESULT_W-8){load_value[7]}}, load_value};

   // a MAC before any load behaves as a plain sum
   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         coeff <= `PEA_RESULT_W'(1);
         bias  <= '0;
      end
      else
      begin
         if (load_coeff)
            coeff <= value_ext;
         if (load_bias)
            bias <= value_ext;
      end
   end

   // one control token names a single command, so both loads cannot coincide
   load_exclusive_a: assert property (
      @(posedge clk) disable iff (!rst)
      !(load_coeff && load_bias)
   );

endmodule

//--- src/pea_defs.svh
`ifndef PEA_DEFS_SVH
`define PEA_DEFS_SVH

`define PEA_TOKEN_W      16
`define PEA_RESULT_W     32
`define PEA_BUFFER_SIZE  1024
`define PEA_CNT_W        11

`define PEA_CMD_SUM        8'd1
`define PEA_CMD_MAC        8'd2
`define PEA_CMD_LOAD_COEFF 8'd3
`define PEA_CMD_LOAD_BIAS  8'd4

`define PEA_STAT_OK      8'h00
`define PEA_STAT_BAD_CMD 8'h01

// bit ranges inside a status token
`define PEA_STAT_CMD   31:24
`define PEA_STAT_CODE  23:16
`define PEA_STAT_PAD   15:8
`define PEA_STAT_COUNT 7:0

`endif

//--- src/pea_enable.sv
`include "pea_defs.svh"

module pea_enable
   import pea_pkg::*;
(
   input  control_token_t         control_in,
   input  logic [`PEA_CNT_W-1:0]  control_pop,
   input  logic [`PEA_CNT_W-1:0]  data_pop,
   input  logic [`PEA_CNT_W-1:0]  result_free_space,
   input  logic [`PEA_CNT_W-1:0]  status_free_space,
   output logic                   can_fire
);

   logic [7:0]            cmd;
   logic                  needs_data;
   logic [`PEA_CNT_W-1:0] data_needed;
   logic                  have_control;
   logic                  have_data;
   logic                  have_space;

   // the head token is only meaningful when the control FIFO is not empty,
   // which the first term of can_fire takes care of
   assign cmd = control_in.op.cmd;

   assign needs_data = (cmd == `PEA_CMD_SUM) || (cmd == `PEA_CMD_MAC);

   // arg1 encodes one less than the number of data tokens
   assign data_needed = {{(`PEA_CNT_W-3){1'b0}}, control_in.op.arg1} + `PEA_CNT_W'(1);

   assign have_control = (control_pop != '0);
   assign have_data    = !needs_data || (data_pop >= data_needed);

   // every firing writes a status token, and space for a result is demanded
   // even for loads so that the rule does not depend on the command
   assign have_space = (result_free_space != '0) && (status_free_space != '0);

   assign can_fire = have_control && have_data && have_space;

endmodule

//--- src/pea_firing_fsm.sv
`include "pea_defs.svh"

module pea_firing_fsm
   import pea_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            start,
   input  control_token_t                  control_in,
   input  logic [`PEA_TOKEN_W-1:0]         data_in,
   input  logic signed [`PEA_RESULT_W-1:0] coeff,
   input  logic signed [`PEA_RESULT_W-1:0] bias,
   output logic                            done,
   output logic                            control_rd_en,
   output logic                            data_rd_en,
   output logic                            result_wr_en,
   output logic                            status_wr_en,
   output logic [`PEA_RESULT_W-1:0]        result_out,
   output logic [`PEA_RESULT_W-1:0]        status_out,
   output logic                            load_coeff,
   output logic                            load_bias,
   output logic signed [7:0]               load_value
);

   localparam logic [2:0] ST_IDLE   = 3'd0;
   localparam logic [2:0] ST_CTRL   = 3'd1;
   localparam logic [2:0] ST_DECODE = 3'd2;
   localparam logic [2:0] ST_DATA   = 3'd3;
   localparam logic [2:0] ST_WRITE  = 3'd4;

   logic [2:0]                      state;
   logic [3:0]                      remaining;
   control_token_t                  token;
   logic signed [`PEA_RESULT_W-1:0] acc;
   logic signed [`PEA_RESULT_W-1:0] data_ext;
   logic signed [`PEA_RESULT_W-1:0] term;
   logic [3:0]                      data_count;
   logic                            is_sum;
   logic                            is_mac;
   logic                            is_data;
   logic                            is_load;

   assign is_sum  = (token.op.cmd == `PEA_CMD_SUM);
   assign is_mac  = (token.op.cmd == `PEA_CMD_MAC);
   assign is_data = is_sum || is_mac;
   assign is_load = (token.load.cmd == `PEA_CMD_LOAD_COEFF) ||
                    (token.load.cmd == `PEA_CMD_LOAD_BIAS);

   assign data_count = {1'b0, token.op.arg1} + 4'd1;

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         state     <= ST_IDLE;
         remaining <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (start)
                  state <= ST_CTRL;
            ST_CTRL:
               state <= ST_DECODE;
            ST_DECODE:
            begin
               remaining <= data_count;
               state     <= is_data ? ST_DATA : ST_WRITE;
            end
            ST_DATA:
            begin
               remaining <= remaining - 4'd1;
               if (remaining == 4'd1)
                  state <= ST_WRITE;
            end
            ST_WRITE:
               state <= ST_IDLE;
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // the head of the control FIFO is captured while it is being popped
   always_ff @(posedge clk)
   begin
      if (state == ST_CTRL)
         token <= control_in;
      if (state == ST_DECODE)
         acc <= '0;
      else if (state == ST_DATA)
         acc <= acc + term;
   end

   assign data_ext = {{(`PEA_RESULT_W-`PEA_TOKEN_W){data_in[`PEA_TOKEN_W-1]}}, data_in};

   // products keep only the low 32 bits, as does the running sum
   assign term = is_mac ? data_ext * coeff : data_ext;

   assign result_out = is_sum ? acc << token.op.arg2 : acc + bias;

   always_comb
   begin
      status_out = '0;
      status_out[`PEA_STAT_CMD] = token.op.cmd;
      status_out[`PEA_STAT_CODE] = (is_data || is_load) ? `PEA_STAT_OK : `PEA_STAT_BAD_CMD;
      status_out[`PEA_STAT_PAD] = 8'h00;
      status_out[`PEA_STAT_COUNT] = is_data ? {4'h0, data_count} : 8'h00;
   end

   assign control_rd_en = (state == ST_CTRL);
   assign data_rd_en    = (state == ST_DATA);
   assign done          = (state == ST_WRITE);
   assign status_wr_en  = done;
   assign result_wr_en  = done && is_data;

   // configuration is updated in the decode cycle, well before the next MAC
   assign load_coeff = (state == ST_DECODE) && (token.load.cmd == `PEA_CMD_LOAD_COEFF);
   assign load_bias  = (state == ST_DECODE) && (token.load.cmd == `PEA_CMD_LOAD_BIAS);
   assign load_value = token.load.imm;

   // a start in the middle of a firing would be dropped by the idle state
   start_when_idle_a: assert property (
      @(posedge clk) disable iff (!rst)
      start |-> (state == ST_IDLE)
   );

endmodule

//--- src/pea_pkg.sv
package pea_pkg;

   // field split used by SUM, MAC and anything that is not a load
   typedef struct packed
   {
      logic [7:0] cmd;
      logic [2:0] arg1;
      logic [4:0] arg2;
   } op_view_t;

   // load commands carry one signed byte in place of the two arguments
   typedef struct packed
   {
      logic [7:0]        cmd;
      logic signed [7:0] imm;
   } imm_view_t;

   // the command byte sits in the same place in both views, so either one
   // can be used to decode which view applies to the rest of the token
   typedef union packed
   {
      op_view_t  op;
      imm_view_t load;
   } control_token_t;

endpackage

//--- src/pea_top.sv
`include "pea_defs.svh"

module pea_top
   import pea_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  control_token_t            control_in,
   input  logic [`PEA_CNT_W-1:0]     control_pop,
   input  logic [`PEA_TOKEN_W-1:0]   data_in,
   input  logic [`PEA_CNT_W-1:0]     data_pop,
   input  logic [`PEA_CNT_W-1:0]     result_free_space,
   input  logic [`PEA_CNT_W-1:0]     status_free_space,
   input  logic                      invoke,
   output logic                      enable,
   output logic                      fc,
   output logic                      control_rd_en,
   output logic                      data_rd_en,
   output logic                      result_wr_en,
   output logic                      status_wr_en,
   output logic [`PEA_RESULT_W-1:0]  result_out,
   output logic [`PEA_RESULT_W-1:0]  status_out
);

   localparam logic [1:0] ST_IDLE         = 2'd0;
   localparam logic [1:0] ST_FIRING_START = 2'd1;
   localparam logic [1:0] ST_FIRING_WAIT  = 2'd2;

   logic [1:0]                      state;
   logic [1:0]                      next_state;
   logic                            can_fire;
   logic                            start;
   logic                            done;
   logic                            load_coeff;
   logic                            load_bias;
   logic signed [7:0]               load_value;
   logic signed [`PEA_RESULT_W-1:0] coeff;
   logic signed [`PEA_RESULT_W-1:0] bias;

   pea_enable u_enable (
      .control_in        (control_in),
      .control_pop       (control_pop),
      .data_pop          (data_pop),
      .result_free_space (result_free_space),
      .status_free_space (status_free_space),
      .can_fire          (can_fire)
   );

   pea_firing_fsm u_firing (
      .clk           (clk),
      .rst           (rst),
      .start         (start),
      .control_in    (control_in),
      .data_in       (data_in),
      .coeff         (coeff),
      .bias          (bias),
      .done          (done),
      .control_rd_en (control_rd_en),
      .data_rd_en    (data_rd_en),
      .result_wr_en  (result_wr_en),
      .status_wr_en  (status_wr_en),
      .result_out    (result_out),
      .status_out    (status_out),
      .load_coeff    (load_coeff),
      .load_bias     (load_bias),
      .load_value    (load_value)
   );

   pea_config_regs u_config (
      .clk        (clk),
      .rst        (rst),
      .load_coeff (load_coeff),
      .load_bias  (load_bias),
      .load_value (load_value),
      .coeff      (coeff),
      .bias       (bias)
   );

   // the scheduler only sees enable between firings
   assign enable = can_fire && (state == ST_IDLE);
   assign fc     = done;

   always_comb
   begin
      next_state = state;
      case (state)
         ST_IDLE:
            if (invoke && enable)
               next_state = ST_FIRING_START;
         ST_FIRING_START:
            next_state = ST_FIRING_WAIT;
         ST_FIRING_WAIT:
            if (done)
               next_state = ST_IDLE;
         default:
            next_state = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         state <= ST_IDLE;
         start <= 1'b0;
      end
      else
      begin
         state <= next_state;
         start <= (state == ST_IDLE) && invoke && enable;
      end
   end

   // completion from the firing FSM is only expected after a start was issued
   fc_after_start_a: assert property (
      @(posedge clk) disable iff (!rst)
      fc |-> (state == ST_FIRING_WAIT)
   );

   counts_in_range_a: assert property (
      @(posedge clk) disable iff (!rst)
      (control_pop <= `PEA_BUFFER_SIZE) && (data_pop <= `PEA_BUFFER_SIZE)
   );

endmodule

//--- verification/pea_tb.sv
`include "pea_defs.svh"

module pea_tb
   import pea_pkg::*;
();

   // roughly 250 firings of up to 12 cycles each, plus the FIFO pushes and margin
   localparam int TIMEOUT_CYCLES = 5000;

   logic                      clk;
   logic                      rst;
   logic                      invoke;
   logic                      ctrl_push;
   logic                      data_push;
   logic [`PEA_TOKEN_W-1:0]   ctrl_wdata;
   logic [`PEA_TOKEN_W-1:0]   data_wdata;
   logic [`PEA_TOKEN_W-1:0]   ctrl_head;
   logic [`PEA_TOKEN_W-1:0]   data_head;
   logic [`PEA_CNT_W-1:0]     ctrl_count;
   logic [`PEA_CNT_W-1:0]     data_count;
   logic [`PEA_CNT_W-1:0]     result_space;
   logic [`PEA_CNT_W-1:0]     status_space;
   logic                      enable;
   logic                      fc;
   logic                      control_rd_en;
   logic                      data_rd_en;
   logic                      result_wr_en;
   logic                      status_wr_en;
   logic [`PEA_RESULT_W-1:0]  result_out;
   logic [`PEA_RESULT_W-1:0]  status_out;

   logic [`PEA_RESULT_W-1:0]        exp_status [$];
   logic [`PEA_RESULT_W-1:0]        exp_result [$];
   logic                            exp_has_result [$];
   logic signed [`PEA_RESULT_W-1:0] model_coeff;
   logic signed [`PEA_RESULT_W-1:0] model_bias;
   logic [`PEA_TOKEN_W-1:0]         words [8];
   logic [15:0]                     lfsr_state;
   logic                            mon_has;
   logic [`PEA_RESULT_W-1:0]        mon_result;
   int                              errors;
   int                              cycle_count;

   pea_token_fifo ctrl_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (ctrl_push),
      .push_data (ctrl_wdata),
      .pop       (control_rd_en),
      .head      (ctrl_head),
      .count     (ctrl_count)
   );

   pea_token_fifo data_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (data_push),
      .push_data (data_wdata),
      .pop       (data_rd_en),
      .head      (data_head),
      .count     (data_count)
   );

   pea_top dut (
      .clk               (clk),
      .rst               (rst),
      .control_in        (ctrl_head),
      .control_pop       (ctrl_count),
      .data_in           (data_head),
      .data_pop          (data_count),
      .result_free_space (result_space),
      .status_free_space (status_space),
      .invoke            (invoke),
      .enable            (enable),
      .fc                (fc),
      .control_rd_en     (control_rd_en),
      .data_rd_en        (data_rd_en),
      .result_wr_en      (result_wr_en),
      .status_wr_en      (status_wr_en),
      .result_out        (result_out),
      .status_out        (status_out)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0])
         return (s >> 1) ^ 16'hB400;
      return s >> 1;
   endfunction

   task automatic random_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   function automatic logic [31:0] sext(input logic [`PEA_TOKEN_W-1:0] w);
      return {{(`PEA_RESULT_W-`PEA_TOKEN_W){w[`PEA_TOKEN_W-1]}}, w};
   endfunction

   // expected {status, result} of one firing, from the command rules
   function automatic logic [63:0] ref_firing(input control_token_t tok,
                                              input logic [`PEA_TOKEN_W-1:0] w [8]);
      logic [31:0] acc;
      logic [31:0] res;
      logic [7:0]  code;
      logic [7:0]  used;
      int          n;
      acc  = '0;
      res  = '0;
      code = `PEA_STAT_OK;
      used = 8'h00;
      n    = int'(tok.op.arg1) + 1;
      case (tok.op.cmd)
         `PEA_CMD_SUM:
         begin
            for (int i = 0; i < n; i++)
               acc = acc + sext(w[i]);
            res  = acc << tok.op.arg2;
            used = 8'(n);
         end
         `PEA_CMD_MAC:
         begin
            for (int i = 0; i < n; i++)
               acc = acc + sext(w[i]) * model_coeff;
            res  = acc + model_bias;
            used = 8'(n);
         end
         `PEA_CMD_LOAD_COEFF, `PEA_CMD_LOAD_BIAS:
            code = `PEA_STAT_OK;
         default:
            code = `PEA_STAT_BAD_CMD;
      endcase
      return {tok.op.cmd, code, 8'h00, used, res};
   endfunction

   function automatic control_token_t make_op(input logic [7:0] cmd, input logic [2:0] a1,
                                              input logic [4:0] a2);
      control_token_t t;
      t.op.cmd  = cmd;
      t.op.arg1 = a1;
      t.op.arg2 = a2;
      return t;
   endfunction

   function automatic control_token_t make_load(input logic [7:0] cmd, input logic [7:0] imm);
      control_token_t t;
      t.load.cmd = cmd;
      t.load.imm = imm;
      return t;
   endfunction

   task automatic report_error(input string msg);
      errors++;
      $display("ERROR: %s at cycle %0d", msg, cycle_count);
   endtask

   task automatic check_result(input logic [`PEA_RESULT_W-1:0] got,
                               input logic [`PEA_RESULT_W-1:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAIL result_out got %08h expected %08h", got, exp);
      end
   endtask

   task automatic check_status(input logic [`PEA_RESULT_W-1:0] got,
                               input logic [`PEA_RESULT_W-1:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAIL status_out got %08h expected %08h", got, exp);
      end
   endtask

   task automatic push_words(input logic [`PEA_TOKEN_W-1:0] w [8], input int first,
                             input int n);
      for (int i = first; i < first + n; i++)
      begin
         @(posedge clk);
         data_push  <= 1'b1;
         data_wdata <= w[i];
      end
      @(posedge clk);
      data_push <= 1'b0;
   endtask

   // records the expectation in firing order, then pushes the token
   task automatic queue_cmd(input control_token_t tok, input logic [`PEA_TOKEN_W-1:0] w [8],
                            input bit with_data);
      logic [63:0] expv;
      bit          is_data;
      is_data = (tok.op.cmd == `PEA_CMD_SUM) || (tok.op.cmd == `PEA_CMD_MAC);
      expv = ref_firing(tok, w);
      exp_status.push_back(expv[63:32]);
      exp_result.push_back(expv[31:0]);
      exp_has_result.push_back(is_data);
      if (tok.load.cmd == `PEA_CMD_LOAD_COEFF)
         model_coeff = {{24{tok.load.imm[7]}}, tok.load.imm};
      if (tok.load.cmd == `PEA_CMD_LOAD_BIAS)
         model_bias = {{24{tok.load.imm[7]}}, tok.load.imm};
      @(posedge clk);
      ctrl_push  <= 1'b1;
      ctrl_wdata <= tok;
      @(posedge clk);
      ctrl_push <= 1'b0;
      if (with_data && is_data)
         push_words(w, 0, int'(tok.op.arg1) + 1);
   endtask

   task automatic fire_one();
      int waited;
      waited = 0;
      @(negedge clk);
      while (!enable && waited < 40)
      begin
         @(negedge clk);
         waited++;
      end
      if (!enable)
      begin
         report_error("enable never rose for a queued command");
         return;
      end
      @(posedge clk);
      invoke <= 1'b1;
      @(posedge clk);
      invoke <= 1'b0;
      waited = 0;
      while (!fc && waited < 40)
      begin
         @(negedge clk);
         waited++;
      end
      if (!fc)
         report_error("firing did not complete after invoke");
   endtask

   task automatic expect_blocked();
      repeat (6)
      begin
         @(negedge clk);
         if (enable)
            report_error("enable high under back-pressure");
      end
      @(posedge clk);
      invoke <= 1'b1;
      @(posedge clk);
      invoke <= 1'b0;
      repeat (4)
      begin
         @(negedge clk);
         if (control_rd_en)
            report_error("invoke was honored while enable was low");
      end
   endtask

   always @(negedge clk)
   begin
      if (rst)
      begin
         if (control_rd_en && ctrl_count == '0)
            report_error("control FIFO read while empty");
         if (data_rd_en && data_count == '0)
            report_error("data FIFO read while empty");
         if (fc && !status_wr_en)
            report_error("firing completed without a status write");
         if (status_wr_en)
         begin
            if (exp_status.size() == 0)
               report_error("status write with no firing expected");
            else
            begin
               check_status(status_out, exp_status.pop_front());
               mon_has    = exp_has_result.pop_front();
               mon_result = exp_result.pop_front();
               if (mon_has && !result_wr_en)
                  report_error("result write missing");
               else if (!mon_has && result_wr_en)
                  report_error("result written for a command that has none");
               else if (mon_has)
                  check_result(result_out, mon_result);
            end
         end
         else if (result_wr_en)
            report_error("result write without a status write");
      end
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES)
      begin
         $display("ERROR: simulation ran out of cycles, errors so far %0d", errors);
         $display("Some tests failed");
         $finish;
      end
   end

   initial
   begin
      logic [31:0]    r;
      control_token_t tok;
      logic [7:0]     cmd;
      rst          = 1'b0;
      invoke       = 1'b0;
      ctrl_push    = 1'b0;
      data_push    = 1'b0;
      ctrl_wdata   = '0;
      data_wdata   = '0;
      result_space = 11'd1024;
      status_space = 11'd1024;
      model_coeff  = 32'sd1;
      model_bias   = '0;
      lfsr_state   = 16'd36490;
      errors       = 0;
      cycle_count  = 0;
      for (int i = 0; i < 8; i++)
         words[i] = '0;

      repeat (5) @(posedge clk);
      rst <= 1'b1;
      repeat (2)
      begin
         @(negedge clk);
         if (enable || fc || control_rd_en || data_rd_en || result_wr_en || status_wr_en)
            report_error("outputs not idle after reset");
      end

      // default coefficient and bias make MAC a plain sum
      words[0] = 16'h0005;
      words[1] = 16'hFFFE;
      words[2] = 16'h1234;
      queue_cmd(make_op(`PEA_CMD_MAC, 3'd2, 5'd0), words, 1);
      fire_one();

      for (int a1 = 0; a1 < 8; a1++)
      begin
         for (int i = 0; i < 8; i++)
            words[i] = 16'h7FF0 ^ 16'(a1 * 16'h0901) ^ 16'(i * 16'h1111);
         queue_cmd(make_op(`PEA_CMD_SUM, 3'(a1), 5'(a1 * 5)), words, 1);
         fire_one();
      end

      queue_cmd(make_load(`PEA_CMD_LOAD_COEFF, 8'hFD), words, 1);
      fire_one();
      queue_cmd(make_load(`PEA_CMD_LOAD_BIAS, 8'h9C), words, 1);
      fire_one();
      queue_cmd(make_op(`PEA_CMD_MAC, 3'd3, 5'd0), words, 1);
      fire_one();
      queue_cmd(make_load(`PEA_CMD_LOAD_COEFF, 8'h7F), words, 1);
      fire_one();
      queue_cmd(make_op(`PEA_CMD_MAC, 3'd7, 5'd0), words, 1);
      fire_one();

      // an unknown command must leave the waiting data word alone
      words[0] = 16'hBEEF;
      queue_cmd(make_op(8'h55, 3'd0, 5'd0), words, 0);
      push_words(words, 0, 1);
      fire_one();
      @(negedge clk);
      if (data_count != 11'd1)
         report_error("unknown command consumed data");
      queue_cmd(make_op(`PEA_CMD_SUM, 3'd0, 5'd0), words, 0);
      fire_one();

      queue_cmd(make_op(`PEA_CMD_SUM, 3'd3, 5'd2), words, 0);
      push_words(words, 0, 2);
      expect_blocked();
      push_words(words, 2, 2);
      fire_one();

      @(posedge clk);
      result_space <= '0;
      queue_cmd(make_op(`PEA_CMD_SUM, 3'd1, 5'd1), words, 1);
      expect_blocked();
      @(posedge clk);
      result_space <= 11'd1024;
      fire_one();

      @(posedge clk);
      status_space <= '0;
      queue_cmd(make_load(`PEA_CMD_LOAD_BIAS, 8'h10), words, 1);
      expect_blocked();
      @(posedge clk);
      status_space <= 11'd1024;
      fire_one();

      for (int k = 0; k < 200; k++)
      begin
         random_bits(3, r);
         if (r[2:0] < 3'd3)
            cmd = `PEA_CMD_SUM;
         else if (r[2:0] < 3'd5)
            cmd = `PEA_CMD_MAC;
         else if (r[2:0] == 3'd5)
            cmd = `PEA_CMD_LOAD_COEFF;
         else if (r[2:0] == 3'd6)
            cmd = `PEA_CMD_LOAD_BIAS;
         else
         begin
            random_bits(7, r);
            cmd = {1'b1, r[6:0]};
         end
         random_bits(8, r);
         tok = make_load(cmd, r[7:0]);
         if (cmd == `PEA_CMD_SUM || cmd == `PEA_CMD_MAC)
         begin
            for (int i = 0; i <= int'(tok.op.arg1); i++)
            begin
               random_bits(16, r);
               words[i] = r[15:0];
            end
         end
         queue_cmd(tok, words, 1);
         fire_one();
      end

      repeat (4) @(negedge clk);
      if (exp_status.size() != 0)
         report_error("firings expected but never written");

      $display("errors: %0d, checks finished at cycle %0d", errors, cycle_count);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

//--- verification/pea_token_fifo.sv
`include "pea_defs.svh"

module pea_token_fifo
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          push,
   input  logic [`PEA_TOKEN_W-1:0]       push_data,
   input  logic                          pop,
   output logic [`PEA_TOKEN_W-1:0]       head,
   output logic [`PEA_CNT_W-1:0]         count
);

   logic [`PEA_TOKEN_W-1:0] mem [`PEA_BUFFER_SIZE];
   logic [9:0]              wr_ptr;
   logic [9:0]              rd_ptr;

   // first-word-fall-through: the oldest word is always visible
   assign head = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            mem[wr_ptr] <= push_data;
            wr_ptr      <= wr_ptr + 10'd1;
         end
         if (pop)
            rd_ptr <= rd_ptr + 10'd1;
         count <= count + {{(`PEA_CNT_W-1){1'b0}}, push}
                        - {{(`PEA_CNT_W-1){1'b0}}, pop};
      end
   end

endmodule
